/* Makefile */
# Verilator build and run for the csr unit testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

SRCS := $(shell cat list.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* csr_access.sv */
// csr access decoder
// decodes the CSR address, builds the read word from the register blocks
// and merges write data for write, set and clear into one write value with
// a strobe per target register

`timescale 1ns/1ps
`default_nettype none

module csr_access #(
  parameter int N_EXT_CNT = 2
) (
  input  wire logic                                       csr_access_i,
  input  wire csr_pkg::csr_addr_u                         csr_addr_i,
  input  wire csr_pkg::csr_op_e                           csr_op_i,
  input  wire logic [31:0]                                csr_wdata_i,
  input  wire logic [3:0]                                 core_id_i,
  input  wire logic [5:0]                                 cluster_id_i,
  input  wire logic                                       mstatus_i,
  input  wire logic [31:0]                                mepc_i,
  input  wire logic [5:0]                                 mcause_i,
  input  wire logic                                       mestatus_i,
  input  wire logic [csr_pkg::N_FIXED_CNT+N_EXT_CNT-1:0]  pcer_i,
  input  wire logic [1:0]                                 pcmr_i,
  input  wire logic [31:0]                                pccr_rdata_i,
  output logic [31:0]                                     wr_data_o,
  output logic                                            mstatus_we_o,
  output logic                                            mepc_we_o,
  output logic                                            mcause_we_o,
  output logic                                            mestatus_we_o,
  output logic                                            pcer_we_o,
  output logic                                            pcmr_we_o,
  output logic                                            pccr_we_o,
  output logic                                            pccr_all_o,
  output logic [4:0]                                      pccr_index_o,
  output logic [31:0]                                     csr_rdata_o
);

  import csr_pkg::*;

  logic        we;         // any modifying access this cycle
  logic        in_window;  // address inside 0x780..0x79F
  logic [31:0] rdata;

  assign we        = csr_access_i && (csr_op_i != NONE);
  assign in_window = (csr_addr_i.pccr.prefix == PCCR_PREFIX);

  ////////////////////////////////////////////////////////////////////////////
  // read word, zero for unmapped and idle cycles
  always_comb
  begin
    rdata = '0;
    if (csr_access_i)
    begin
      case (csr_addr_i.raw)
        ADDR_MSTATUS:  rdata = {29'b0, 2'b11, mstatus_i};   // always M-mode
        ADDR_MEPC:     rdata = mepc_i;
        ADDR_MCAUSE:   rdata = {mcause_i[5], 26'b0, mcause_i[4:0]};
        ADDR_MESTATUS: rdata = {29'b0, 2'b11, mestatus_i};
        ADDR_MCPUID:   rdata = MCPUID_VAL;
        ADDR_MIMPID:   rdata = MIMPID_VAL;
        ADDR_MHARTID:  rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
        ADDR_PCER:     rdata = 32'(pcer_i);
        ADDR_PCMR:     rdata = {30'b0, pcmr_i};
        default:
        begin
          // broadcast address has no single value to show
          if (in_window && (csr_addr_i.raw != ADDR_PCCR_ALL))
            rdata = pccr_rdata_i;
        end
      endcase
    end
  end

  assign csr_rdata_o = rdata;

  ////////////////////////////////////////////////////////////////////////////
  // read-modify-write merge
  always_comb
  begin
    case (csr_op_i)
      SET:     wr_data_o = rdata | csr_wdata_i;
      CLEAR:   wr_data_o = rdata & ~csr_wdata_i;
      default: wr_data_o = csr_wdata_i;    // write, none is never strobed
    endcase
  end

  // one strobe per target
  assign mstatus_we_o  = we && (csr_addr_i.raw == ADDR_MSTATUS);
  assign mepc_we_o     = we && (csr_addr_i.raw == ADDR_MEPC);
  assign mcause_we_o   = we && (csr_addr_i.raw == ADDR_MCAUSE);
  assign mestatus_we_o = we && (csr_addr_i.raw == ADDR_MESTATUS);
  assign pcer_we_o     = we && (csr_addr_i.raw == ADDR_PCER);
  assign pcmr_we_o     = we && (csr_addr_i.raw == ADDR_PCMR);
  assign pccr_we_o     = we && in_window;   // includes the broadcast address

  assign pccr_all_o    = csr_access_i && (csr_addr_i.raw == ADDR_PCCR_ALL);
  assign pccr_index_o  = csr_addr_i.pccr.index;

endmodule

`default_nettype wire

/* csr_pkg.sv */
// csr package
// operation codes, register addresses and the address union shared by the
// control and status register unit and its testbench

`default_nettype none

package csr_pkg;

  // access operation, same encoding as the core decoder
  typedef enum logic [1:0] {
    NONE  = 2'b00,
    WRITE = 2'b01,
    SET   = 2'b10,
    CLEAR = 2'b11
  } csr_op_e;

  // one address word, two readings of it
  typedef union packed {
    logic [11:0] raw;               // full address for named registers
    struct packed {
      logic [6:0] prefix;           // 0x3C marks the counter window
      logic [4:0] index;            // counter number inside the window
    } pccr;
  } csr_addr_u;

  ////////////////////////////////////////////////////////////////////////////
  // machine registers
  localparam logic [11:0] ADDR_MSTATUS  = 12'h300;
  localparam logic [11:0] ADDR_MEPC     = 12'h341;
  localparam logic [11:0] ADDR_MCAUSE   = 12'h342;
  localparam logic [11:0] ADDR_MESTATUS = 12'h7C0;

  // read-only identity
  localparam logic [11:0] ADDR_MCPUID   = 12'hF00;
  localparam logic [11:0] ADDR_MIMPID   = 12'hF01;
  localparam logic [11:0] ADDR_MHARTID  = 12'hF10;

  ////////////////////////////////////////////////////////////////////////////
  // performance counter block
  localparam logic [11:0] ADDR_PCER     = 12'h7A0;
  localparam logic [11:0] ADDR_PCMR     = 12'h7A1;
  localparam logic [11:0] ADDR_PCCR_ALL = 12'h79F;   // broadcast to all counters
  localparam logic [6:0]  PCCR_PREFIX   = 7'h3C;     // 0x780..0x79F

  localparam logic [31:0] MCPUID_VAL    = 32'h0080_1100;  // RV32IM plus extensions
  localparam logic [31:0] MIMPID_VAL    = 32'h0000_8000;

  localparam int N_FIXED_CNT = 11;                   // built-in event counters

endpackage

`default_nettype wire

/* csr_unit.sv */
// control and status register unit
// top level joining the access decoder, machine registers, counter
// configuration and counter array

`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
  parameter int N_EXT_CNT = 2
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [3:0]            core_id_i,
  input  wire logic [5:0]            cluster_id_i,
  // register access
  input  wire logic                  csr_access_i,
  input  wire logic [11:0]           csr_addr_i,
  input  wire logic [31:0]           csr_wdata_i,
  input  wire csr_pkg::csr_op_e      csr_op_i,
  output logic [31:0]                csr_rdata_o,
  output logic                       irq_enable_o,
  output logic [31:0]                mepc_o,
  // exception control
  input  wire logic [31:0]           pc_if_i,
  input  wire logic [31:0]           pc_id_i,
  input  wire logic [31:0]           branch_target_i,
  input  wire logic                  data_load_event_ex_i,
  input  wire logic                  exc_save_if_i,
  input  wire logic                  exc_save_id_i,
  input  wire logic                  exc_save_takenbranch_i,
  input  wire logic                  exc_restore_i,
  input  wire logic [5:0]            exc_cause_i,
  input  wire logic                  save_exc_cause_i,
  // counter events
  input  wire logic                  id_valid_i,
  input  wire logic                  is_compressed_i,
  input  wire logic                  is_decoding_i,
  input  wire logic                  imiss_i,
  input  wire logic                  pc_set_i,
  input  wire logic                  jump_i,
  input  wire logic                  branch_i,
  input  wire logic                  branch_taken_i,
  input  wire logic                  ld_stall_i,
  input  wire logic                  jr_stall_i,
  input  wire logic                  mem_load_i,
  input  wire logic                  mem_store_i,
  input  wire logic [N_EXT_CNT-1:0]  ext_counters_i
);

  import csr_pkg::*;

  logic [31:0]                      wr_data;
  logic                             mstatus_we, mepc_we, mcause_we, mestatus_we;
  logic                             pcer_we, pcmr_we, pccr_we;
  logic                             pccr_all;
  logic [4:0]                       pccr_index;
  logic                             mstatus, mestatus;
  logic [31:0]                      mepc;
  logic [5:0]                       mcause;
  logic [N_FIXED_CNT+N_EXT_CNT-1:0] pcer;
  logic [1:0]                       pcmr;
  logic [31:0]                      pccr_rdata;

  csr_access #(.N_EXT_CNT(N_EXT_CNT)) u_access (
    .csr_access_i (csr_access_i),  .csr_addr_i    (csr_addr_i),
    .csr_op_i     (csr_op_i),      .csr_wdata_i   (csr_wdata_i),
    .core_id_i    (core_id_i),     .cluster_id_i  (cluster_id_i),
    .mstatus_i    (mstatus),       .mepc_i        (mepc),
    .mcause_i     (mcause),        .mestatus_i    (mestatus),
    .pcer_i       (pcer),          .pcmr_i        (pcmr),
    .pccr_rdata_i (pccr_rdata),    .wr_data_o     (wr_data),
    .mstatus_we_o (mstatus_we),    .mepc_we_o     (mepc_we),
    .mcause_we_o  (mcause_we),     .mestatus_we_o (mestatus_we),
    .pcer_we_o    (pcer_we),       .pcmr_we_o     (pcmr_we),
    .pccr_we_o    (pccr_we),       .pccr_all_o    (pccr_all),
    .pccr_index_o (pccr_index),    .csr_rdata_o   (csr_rdata_o)
  );

  machine_csrs u_machine (
    .clk                    (clk),                    .rst_n          (rst_n),
    .wr_data_i              (wr_data),                .mstatus_we_i   (mstatus_we),
    .mepc_we_i              (mepc_we),                .mcause_we_i    (mcause_we),
    .mestatus_we_i          (mestatus_we),            .pc_if_i        (pc_if_i),
    .pc_id_i                (pc_id_i),                .branch_target_i(branch_target_i),
    .data_load_event_ex_i   (data_load_event_ex_i),   .exc_save_if_i  (exc_save_if_i),
    .exc_save_id_i          (exc_save_id_i),          .exc_restore_i  (exc_restore_i),
    .exc_save_takenbranch_i (exc_save_takenbranch_i), .exc_cause_i    (exc_cause_i),
    .save_exc_cause_i       (save_exc_cause_i),       .mstatus_o      (mstatus),
    .mepc_o                 (mepc),                   .mcause_o       (mcause),
    .mestatus_o             (mestatus),               .irq_enable_o   (irq_enable_o)
  );

  assign mepc_o = mepc;

  perf_cfg_regs #(.N_EXT_CNT(N_EXT_CNT)) u_cfg (
    .clk       (clk),      .rst_n     (rst_n),
    .wr_data_i (wr_data),  .pcer_we_i (pcer_we),
    .pcmr_we_i (pcmr_we),  .pcer_o    (pcer),
    .pcmr_o    (pcmr)
  );

  perf_counters #(.N_EXT_CNT(N_EXT_CNT)) u_counters (
    .clk             (clk),             .rst_n           (rst_n),
    .id_valid_i      (id_valid_i),      .is_compressed_i (is_compressed_i),
    .is_decoding_i   (is_decoding_i),   .imiss_i         (imiss_i),
    .pc_set_i        (pc_set_i),        .jump_i          (jump_i),
    .branch_i        (branch_i),        .branch_taken_i  (branch_taken_i),
    .ld_stall_i      (ld_stall_i),      .jr_stall_i      (jr_stall_i),
    .mem_load_i      (mem_load_i),      .mem_store_i     (mem_store_i),
    .ext_counters_i  (ext_counters_i),  .pcer_i          (pcer),
    .pcmr_i          (pcmr),            .wr_data_i       (wr_data),
    .pccr_we_i       (pccr_we),         .pccr_all_i      (pccr_all),
    .pccr_index_i    (pccr_index),      .pccr_rdata_o    (pccr_rdata)
  );

endmodule

`default_nettype wire

/* csr_unit_sva.sv */
// bound checks for the csr unit
// input rules on the exception port, reset state of the outputs and
// exclusive access strobes

`timescale 1ns/1ps
`default_nettype none

module csr_unit_sva (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        data_load_event_ex_i,
  input wire logic        exc_save_takenbranch_i,
  input wire logic        irq_enable_o,
  input wire logic [31:0] mepc_o,
  input wire logic [6:0]  strobes_i   // internal write enables
);

  // pipeline never flags both at once
  a_save_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(exc_save_takenbranch_i && data_load_event_ex_i))
    else $error("taken-branch save with data load event");

  a_reset_out: assert property (@(posedge clk)
    !rst_n |-> (!irq_enable_o && (mepc_o == 32'h0)))
    else $error("outputs not in reset state");

  // one target per access at most
  a_we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(strobes_i))
    else $error("more than one write strobe active");

endmodule

bind csr_unit csr_unit_sva u_sva (
  .clk                    (clk),
  .rst_n                  (rst_n),
  .data_load_event_ex_i   (data_load_event_ex_i),
  .exc_save_takenbranch_i (exc_save_takenbranch_i),
  .irq_enable_o           (irq_enable_o),
  .mepc_o                 (mepc_o),
  .strobes_i              ({mstatus_we, mepc_we, mcause_we, mestatus_we,
                            pcer_we, pcmr_we, pccr_we})
);

`default_nettype wire

/* list.f */
csr_pkg.sv
csr_access.sv
machine_csrs.sv
perf_cfg_regs.sv
perf_counters.sv
csr_unit.sv
csr_unit_sva.sv
tb_csr_unit.sv

/* machine_csrs.sv */
// machine mode registers
// mstatus interrupt enable, exception pc, cause and saved status, with the
// hardware save and restore done on exception entry and return

`timescale 1ns/1ps
`default_nettype none

module machine_csrs (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [31:0] wr_data_i,
  input  wire logic        mstatus_we_i,
  input  wire logic        mepc_we_i,
  input  wire logic        mcause_we_i,
  input  wire logic        mestatus_we_i,
  input  wire logic [31:0] pc_if_i,
  input  wire logic [31:0] pc_id_i,
  input  wire logic [31:0] branch_target_i,
  input  wire logic        data_load_event_ex_i,
  input  wire logic        exc_save_if_i,
  input  wire logic        exc_save_id_i,
  input  wire logic        exc_save_takenbranch_i,
  input  wire logic        exc_restore_i,
  input  wire logic [5:0]  exc_cause_i,
  input  wire logic        save_exc_cause_i,
  output logic             mstatus_o,
  output logic [31:0]      mepc_o,
  output logic [5:0]       mcause_o,
  output logic             mestatus_o,
  output logic             irq_enable_o
);

  logic        mstatus_q, mstatus_n;    // IE bit
  logic        mestatus_q, mestatus_n;  // IE saved on exception
  logic [31:0] mepc_q, mepc_n;
  logic [5:0]  mcause_q, mcause_n;
  logic        exc_save;

  assign exc_save = exc_save_if_i || exc_save_id_i || exc_save_takenbranch_i;

  // later assignments win, so hardware events come after software writes
  always_comb
  begin
    mstatus_n  = mstatus_q;
    mestatus_n = mestatus_q;
    mepc_n     = mepc_q;
    mcause_n   = mcause_q;

    if (mstatus_we_i)  mstatus_n  = wr_data_i[0];
    if (mestatus_we_i) mestatus_n = wr_data_i[0];
    if (mepc_we_i)     mepc_n     = wr_data_i;
    if (mcause_we_i)   mcause_n   = wr_data_i[5:0];

    if (exc_save)
    begin
      mestatus_n = mstatus_q;
      mstatus_n  = 1'b0;           // no nested interrupts
      if (data_load_event_ex_i)
        mepc_n = pc_id_i;          // faulting load sits in ID
      else if (exc_save_takenbranch_i)
        mepc_n = branch_target_i;
      else if (exc_save_if_i)
        mepc_n = pc_if_i;
      else
        mepc_n = pc_id_i;
    end

    if (save_exc_cause_i)
      mcause_n = exc_cause_i;

    if (exc_restore_i)
      mstatus_n = mestatus_q;      // return from exception
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      mstatus_q  <= 1'b0;
      mestatus_q <= 1'b0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end
    else
    begin
      mstatus_q  <= mstatus_n;
      mestatus_q <= mestatus_n;
      mepc_q     <= mepc_n;
      mcause_q   <= mcause_n;
    end
  end

  assign mstatus_o    = mstatus_q;
  assign mestatus_o   = mestatus_q;
  assign mepc_o       = mepc_q;
  assign mcause_o     = mcause_q;
  assign irq_enable_o = mstatus_q;

endmodule

`default_nettype wire

/* perf_cfg_regs.sv */
// performance counter configuration
// PCER holds one enable per counter, PCMR the global enable (bit 0) and the
// saturate mode (bit 1)

`timescale 1ns/1ps
`default_nettype none

module perf_cfg_regs #(
  parameter int N_EXT_CNT = 2
) (
  input  wire logic                                       clk,
  input  wire logic                                       rst_n,
  input  wire logic [31:0]                                wr_data_i,
  input  wire logic                                       pcer_we_i,
  input  wire logic                                       pcmr_we_i,
  output logic [csr_pkg::N_FIXED_CNT+N_EXT_CNT-1:0]       pcer_o,
  output logic [1:0]                                      pcmr_o
);

  import csr_pkg::*;

  localparam int N_CNT = N_FIXED_CNT + N_EXT_CNT;

  logic [N_CNT-1:0] pcer_q;
  logic [1:0]       pcmr_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      pcer_q <= '0;       // all counters off
      pcmr_q <= 2'b11;    // enabled, saturating
    end
    else
    begin
      if (pcer_we_i) pcer_q <= wr_data_i[N_CNT-1:0];
      if (pcmr_we_i) pcmr_q <= wr_data_i[1:0];
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

endmodule

`default_nettype wire

/* perf_counters.sv */
// performance counter array
// conditions the core events, registers the enabled increments and keeps
// one 32-bit counter per event with optional saturation

`timescale 1ns/1ps
`default_nettype none

module perf_counters #(
  parameter int N_EXT_CNT = 2
) (
  input  wire logic                                       clk,
  input  wire logic                                       rst_n,
  input  wire logic                                       id_valid_i,
  input  wire logic                                       is_compressed_i,
  input  wire logic                                       is_decoding_i,
  input  wire logic                                       imiss_i,
  input  wire logic                                       pc_set_i,
  input  wire logic                                       jump_i,
  input  wire logic                                       branch_i,
  input  wire logic                                       branch_taken_i,
  input  wire logic                                       ld_stall_i,
  input  wire logic                                       jr_stall_i,
  input  wire logic                                       mem_load_i,
  input  wire logic                                       mem_store_i,
  input  wire logic [N_EXT_CNT-1:0]                       ext_counters_i,
  input  wire logic [csr_pkg::N_FIXED_CNT+N_EXT_CNT-1:0]  pcer_i,
  input  wire logic [1:0]                                 pcmr_i,
  input  wire logic [31:0]                                wr_data_i,
  input  wire logic                                       pccr_we_i,
  input  wire logic                                       pccr_all_i,
  input  wire logic [4:0]                                 pccr_index_i,
  output logic [31:0]                                     pccr_rdata_o
);

  import csr_pkg::*;

  localparam int N_CNT = N_FIXED_CNT + N_EXT_CNT;

  logic                        id_valid_q;
  logic [N_CNT-1:0]            evt;         // raw events
  logic [N_CNT-1:0]            inc;         // enabled events
  logic [N_CNT-1:0]            inc_q;       // one cycle later
  logic [N_CNT-1:0][31:0]      cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // event conditioning
  assign evt[0]  = 1'b1;                              // cycles
  assign evt[1]  = id_valid_i & is_decoding_i;        // instructions
  assign evt[2]  = ld_stall_i & id_valid_q;           // load-use stalls
  assign evt[3]  = jr_stall_i & id_valid_q;           // jump register stalls
  assign evt[4]  = imiss_i & ~pc_set_i;               // fetch wait outside redirects
  assign evt[5]  = mem_load_i;
  assign evt[6]  = mem_store_i;
  assign evt[7]  = jump_i & id_valid_q;
  assign evt[8]  = branch_i & id_valid_q;
  assign evt[9]  = branch_i & branch_taken_i & id_valid_q;
  assign evt[10] = id_valid_i & is_decoding_i & is_compressed_i;

  // external events follow the fixed ones
  for (genvar g = 0; g < N_EXT_CNT; g++)
  begin : g_ext
    assign evt[N_FIXED_CNT+g] = ext_counters_i[g];
  end

  assign inc = evt & pcer_i & {N_CNT{pcmr_i[0]}};

  ////////////////////////////////////////////////////////////////////////////
  // counter array
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      cnt_q      <= '0;
    end
    else
    begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;
      for (int i = 0; i < N_CNT; i++)
      begin
        // software write beats the pending increment
        if (pccr_we_i && (pccr_all_i || (pccr_index_i == 5'(i))))
          cnt_q[i] <= wr_data_i;
        else if (inc_q[i] && !(pcmr_i[1] && (&cnt_q[i])))
          cnt_q[i] <= cnt_q[i] + 32'd1;
      end
    end
  end

  // indices past the last counter read zero
  always_comb
  begin
    pccr_rdata_o = '0;
    for (int i = 0; i < N_CNT; i++)
    begin
      if (pccr_index_i == 5'(i))
        pccr_rdata_o = cnt_q[i];
    end
  end

endmodule

`default_nettype wire

/* tb_csr_unit.sv */
// testbench for the control and status register unit
// drives the access port, exception and event inputs directly and checks
// read data, irq enable and mepc against a shadow model of the registers

`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

  import csr_pkg::*;

  localparam int N_EXT      = 2;
  localparam int N_CNT      = N_FIXED_CNT + N_EXT;
  localparam int MAX_CYCLES = 320;    // twice the roughly 155 cycles of all tests

  logic             clk, rst_n;
  logic [3:0]       core_id_i;
  logic [5:0]       cluster_id_i;
  logic             csr_access_i;
  logic [11:0]      csr_addr_i;
  logic [31:0]      csr_wdata_i;
  csr_op_e          csr_op_i;
  logic [31:0]      csr_rdata_o, mepc_o;
  logic             irq_enable_o;
  logic [31:0]      pc_if_i, pc_id_i, branch_target_i;
  logic             data_load_event_ex_i, exc_save_if_i, exc_save_id_i;
  logic             exc_save_takenbranch_i, exc_restore_i, save_exc_cause_i;
  logic [5:0]       exc_cause_i;
  logic             id_valid_i, is_compressed_i, is_decoding_i, imiss_i, pc_set_i;
  logic             jump_i, branch_i, branch_taken_i, ld_stall_i, jr_stall_i;
  logic             mem_load_i, mem_store_i;
  logic [N_EXT-1:0] ext_counters_i;

  integer seed;
  int     errors, checks, tests_ok, tests_bad, test_err0;
  int     cycles = 0;

  // shadow model of the machine registers
  logic        m_mstatus, m_mestatus;
  logic [31:0] m_mepc;
  logic [5:0]  m_mcause;

  csr_unit #(.N_EXT_CNT(N_EXT)) dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  // run limit
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("timeout: run exceeded %0d cycles without finishing", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk);
    #10;                      // drive point after the edge
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // expected read word of a machine register
  function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
      ADDR_MSTATUS:  return {29'b0, 2'b11, m_mstatus};
      ADDR_MEPC:     return m_mepc;
      ADDR_MCAUSE:   return {m_mcause[5], 26'b0, m_mcause[4:0]};
      ADDR_MESTATUS: return {29'b0, 2'b11, m_mestatus};
      default:       return 32'h0;
    endcase
  endfunction

  task automatic model_write(input csr_op_e op, input logic [11:0] addr,
                             input logic [31:0] wd);
    logic [31:0] m;
    m = (op == SET) ? (model_read(addr) | wd) :
        (op == CLEAR) ? (model_read(addr) & ~wd) : wd;
    case (addr)
      ADDR_MSTATUS:  m_mstatus  = m[0];
      ADDR_MESTATUS: m_mestatus = m[0];
      ADDR_MEPC:     m_mepc     = m;
      ADDR_MCAUSE:   m_mcause   = m[5:0];
      default:       ;
    endcase
  endtask

  // one-cycle access committed at the next edge
  task automatic access(input csr_op_e op, input logic [11:0] addr, input logic [31:0] wd);
    csr_access_i = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = addr;
    csr_wdata_i  = wd;
    tick();
    csr_access_i = 1'b0;
    csr_op_i     = NONE;
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                            input string name);
    csr_access_i = 1'b1;
    csr_op_i     = NONE;
    csr_addr_i   = addr;
    #20;                      // combinational rdata sampled mid cycle
    check(name, exp, csr_rdata_o);
    tick();
    csr_access_i = 1'b0;
  endtask

  task automatic check_outputs();
    check("irq_enable_o", {31'b0, m_mstatus}, {31'b0, irq_enable_o});
    check("mepc_o", m_mepc, mepc_o);
  endtask

  // exception save of one kind with mepc picked by priority
  task automatic exc_save(input logic sif, input logic sid, input logic stb,
                          input logic dle);
    pc_if_i                = $random(seed);
    pc_id_i                = $random(seed);
    branch_target_i        = $random(seed);
    exc_save_if_i          = sif;
    exc_save_id_i          = sid;
    exc_save_takenbranch_i = stb;
    data_load_event_ex_i   = dle;
    m_mestatus = m_mstatus;
    m_mstatus  = 1'b0;
    if (dle)      m_mepc = pc_id_i;
    else if (stb) m_mepc = branch_target_i;
    else if (sif) m_mepc = pc_if_i;
    else          m_mepc = pc_id_i;
    tick();
    exc_save_if_i          = 1'b0;
    exc_save_id_i          = 1'b0;
    exc_save_takenbranch_i = 1'b0;
    data_load_event_ex_i   = 1'b0;
    csr_access_i           = 1'b0;
    csr_op_i               = NONE;
    check_outputs();
    read_check(ADDR_MESTATUS, model_read(ADDR_MESTATUS), "mestatus");
  endtask

  task automatic exc_return();
    exc_restore_i = 1'b1;
    tick();
    exc_restore_i = 1'b0;
    m_mstatus     = m_mestatus;
    check_outputs();
  endtask

  task automatic end_test(input string name);
    if (errors == test_err0)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  initial
  begin
    logic [11:0] maddr [3];
    logic [31:0] wd, v;
    logic [1:0]  sel;
    csr_op_e     op;

    seed       = 32'h6f7e_2daf;
    errors     = 0;
    checks     = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    test_err0  = 0;
    maddr      = '{ADDR_MEPC, ADDR_MCAUSE, ADDR_MSTATUS};
    m_mstatus  = 1'b0;
    m_mestatus = 1'b0;
    m_mepc     = '0;
    m_mcause   = '0;

    rst_n                  = 1'b0;
    core_id_i              = 4'h5;
    cluster_id_i           = 6'h2a;
    csr_access_i           = 1'b0;
    csr_addr_i             = '0;
    csr_wdata_i            = '0;
    csr_op_i               = NONE;
    pc_if_i                = '0;
    pc_id_i                = '0;
    branch_target_i        = '0;
    data_load_event_ex_i   = 1'b0;
    exc_save_if_i          = 1'b0;
    exc_save_id_i          = 1'b0;
    exc_save_takenbranch_i = 1'b0;
    exc_restore_i          = 1'b0;
    exc_cause_i            = '0;
    save_exc_cause_i       = 1'b0;
    id_valid_i             = 1'b0;
    is_compressed_i        = 1'b0;
    is_decoding_i          = 1'b0;
    imiss_i                = 1'b0;
    pc_set_i               = 1'b0;
    jump_i                 = 1'b0;
    branch_i               = 1'b0;
    branch_taken_i         = 1'b0;
    ld_stall_i             = 1'b0;
    jr_stall_i             = 1'b0;
    mem_load_i             = 1'b0;
    mem_store_i            = 1'b0;
    ext_counters_i         = '0;

    repeat (8) @(posedge clk);
    #10 rst_n = 1'b1;

    // identity and reset
    check_outputs();
    read_check(ADDR_MHARTID, 32'h0000_0545, "mhartid");   // cluster 0x2a, core 5
    read_check(ADDR_MCPUID, 32'h0080_1100, "mcpuid");
    read_check(ADDR_MIMPID, 32'h0000_8000, "mimpid");
    read_check(ADDR_MSTATUS, 32'h6, "mstatus");
    read_check(ADDR_MEPC, 32'h0, "mepc");
    read_check(ADDR_MCAUSE, 32'h0, "mcause");
    read_check(ADDR_PCER, 32'h0, "pcer");
    read_check(ADDR_PCMR, 32'h3, "pcmr");
    read_check(12'h780, 32'h0, "pccr0");
    end_test("identity_reset");

    // read-modify-write, every op on every register with random data
    for (int i = 0; i < 12; i++)
    begin
      sel = 2'((i / 3) % 3);
      op  = (i % 3 == 0) ? WRITE : (i % 3 == 1) ? SET : CLEAR;
      wd  = $random(seed);
      model_write(op, maddr[sel], wd);
      access(op, maddr[sel], wd);
      check_outputs();
      read_check(maddr[sel], model_read(maddr[sel]), "rmw readback");
    end
    csr_op_i    = WRITE;            // write without access strobe
    csr_addr_i  = ADDR_MEPC;
    csr_wdata_i = ~m_mepc;
    tick();
    csr_op_i = NONE;
    access(NONE, ADDR_MEPC, ~m_mepc);
    check_outputs();
    read_check(ADDR_MEPC, m_mepc, "mepc after idle");
    read_check(12'h123, 32'h0, "unmapped");
    read_check(12'h7FF, 32'h0, "unmapped");
    end_test("read_modify_write");

    // exception save and restore
    access(WRITE, ADDR_MSTATUS, 32'h1);
    m_mstatus = 1'b1;
    exc_save(1'b1, 1'b0, 1'b0, 1'b0);
    exc_return();
    exc_save(1'b0, 1'b0, 1'b1, 1'b0);
    exc_return();
    exc_save(1'b1, 1'b1, 1'b0, 1'b1);   // load event beats the IF pc
    exc_return();
    exc_cause_i      = 6'h2b;
    save_exc_cause_i = 1'b1;
    tick();
    save_exc_cause_i = 1'b0;
    m_mcause = 6'h2b;
    read_check(ADDR_MCAUSE, 32'h8000_000b, "mcause");
    csr_access_i = 1'b1;                // software write in the save cycle
    csr_op_i     = WRITE;
    csr_addr_i   = ADDR_MEPC;
    csr_wdata_i  = 32'hdead_beef;
    exc_save(1'b0, 1'b1, 1'b0, 1'b0);
    exc_return();
    end_test("exception");

    // counting
    access(WRITE, ADDR_PCMR, 32'h1);
    access(WRITE, ADDR_PCER, 32'h0000_0863);   // cycles, instr, load, store, ext0
    repeat (5) tick();
    read_check(12'h780, 32'd4, "cycle count");  // two-edge latency
    for (int i = 0; i < 5; i++)
    begin
      mem_load_i        = 1'b1;
      mem_store_i       = (i < 3);
      id_valid_i        = (i < 4);
      is_decoding_i     = 1'b1;
      ext_counters_i[0] = (i < 2);
      ext_counters_i[1] = 1'b1;                 // counter 12 stays off in PCER
      tick();
      mem_load_i     = 1'b0;
      mem_store_i    = 1'b0;
      id_valid_i     = 1'b0;
      is_decoding_i  = 1'b0;
      ext_counters_i = '0;
      tick();
    end
    repeat (2) tick();
    read_check(12'h781, 32'd4, "instr count");
    read_check(12'h785, 32'd5, "load count");
    read_check(12'h786, 32'd3, "store count");
    read_check(12'h78B, 32'd2, "ext0 count");
    read_check(12'h78C, 32'd0, "ext1 count");
    access(CLEAR, ADDR_PCMR, 32'h1);            // global enable off
    repeat (2) tick();
    access(WRITE, 12'h780, 32'd100);
    repeat (5) tick();
    read_check(12'h780, 32'd100, "frozen cycles");
    read_check(ADDR_PCMR, 32'h0, "pcmr");
    end_test("counting");

    // saturation and wrap
    access(WRITE, 12'h780, 32'hffff_fffe);
    access(WRITE, ADDR_PCMR, 32'h3);
    repeat (6) tick();
    read_check(12'h780, 32'hffff_ffff, "saturated");
    access(WRITE, ADDR_PCMR, 32'h1);
    read_check(12'h780, 32'hffff_ffff, "before wrap");
    read_check(12'h780, 32'h0, "wrapped");
    read_check(12'h780, 32'h1, "after wrap");
    end_test("saturation");

    // broadcast write then one value per counter
    access(WRITE, ADDR_PCMR, 32'h0);
    repeat (2) tick();
    v = $random(seed);
    access(WRITE, ADDR_PCCR_ALL, v);
    for (int i = 0; i < N_CNT; i++)
      read_check({PCCR_PREFIX, 5'(i)}, v, "pccr broadcast");
    read_check(ADDR_PCCR_ALL, 32'h0, "pccr_all read");
    for (int i = 0; i < N_CNT; i++)
      access(WRITE, {PCCR_PREFIX, 5'(i)}, v ^ (32'h0101_0101 * 32'(i)));
    for (int i = 0; i < N_CNT; i++)
      read_check({PCCR_PREFIX, 5'(i)}, v ^ (32'h0101_0101 * 32'(i)), "pccr own");
    end_test("all_counter_write");

    $display("tests: %0d ok, %0d failed; checks: %0d, errors: %0d",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire
